/* logic/noc_pkg.sv */
package noc_pkg;

   //////////////////////////////
   // mesh geometry
   //////////////////////////////

   // 4x4 mesh of routers
   localparam int X_NODES = 4;
   localparam int Y_NODES = 4;

   // bits per coordinate
   // sized for the larger of the two dimensions
   localparam int COORD_W = $clog2((X_NODES > Y_NODES) ? X_NODES : Y_NODES);

   //////////////////////////////
   // router ports
   //////////////////////////////

   // local plus four neighbours
   localparam int NUM_PORTS = 5;

   // port numbering
   // bit i of every request or grant vector belongs to port i
   typedef enum logic [2:0] {
      PORT_L = 3'd0,
      PORT_E = 3'd1,
      PORT_N = 3'd2,
      PORT_W = 3'd3,
      PORT_S = 3'd4
   } port_e;

endpackage

/* logic/flit_pkg.sv */
package flit_pkg;

   // whole flit, single-flit packets only
   localparam int FLIT_W = 8;

   // payload gets whatever the two coordinates leave over
   localparam int PAYLOAD_W = FLIT_W - 2 * noc_pkg::COORD_W;

   // field layout, lsb first
   //   [1:0] dest x
   //   [3:2] dest y
   //   [7:4] payload
   typedef struct packed {
      logic [PAYLOAD_W-1:0]        payload;
      logic [noc_pkg::COORD_W-1:0] dest_y;
      logic [noc_pkg::COORD_W-1:0] dest_x;
   } flit_t;

endpackage

/* logic/head_if.sv */
`timescale 1ns/100ps

// queue head of one input port
// shared by the buffer, its route logic and the allocator
interface head_if;

   // head flit present
   logic valid;
   // oldest flit in the buffer
   flit_pkg::flit_t head;
   // one-hot output request, bit i is port i
   logic [noc_pkg::NUM_PORTS-1:0] req;
   // head consumed this cycle
   // only ever high together with valid
   logic pop;

   // input buffer owns the head
   modport buffer (output valid, output head, input pop);

   // route logic turns the head into a request
   modport route (input valid, input head, output req);

   // allocator grants and pops
   modport alloc (input valid, input req, output pop);

endinterface

/* logic/flit_fifo.sv */
`timescale 1ns/100ps

module flit_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic            clk,
   input  logic            rst_n,
   // write-only wishbone slave
   input  logic            cyc,
   input  logic            stb,
   input  flit_pkg::flit_t dat,
   output logic            ack,
   // queue head towards route logic and allocator
   head_if.buffer          q
);

   // pointer width of at least one bit
   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(FIFO_DEPTH);

   flit_pkg::flit_t  mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             wr_en;

   // write completes on stb and ack together
   assign wr_en = cyc & stb & ack;

   // head is visible the cycle after the write
   assign q.valid = (count != '0);
   assign q.head  = mem[rd_ptr];

   //////////////////////////////
   // ack and bookkeeping
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack    <= 1'b0;
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // one-cycle ack that never comes twice in a row
         // space test ignores a pop in this cycle
         ack <= cyc & stb & ~ack & (count != FULL_CNT);

         if (wr_en) begin
            wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
         end
         if (q.pop) begin
            rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
         end

         // occupancy
         case ({wr_en, q.pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // flit storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= dat;
      end
   end

endmodule

/* logic/route_compute.sv */
`timescale 1ns/100ps

module route_compute #(
   parameter int X_POS = 1,
   parameter int Y_POS = 1
) (
   head_if.route q
);

   localparam int CW = noc_pkg::COORD_W;

   // own position, one extra bit for the signed difference
   localparam logic [CW:0] X_SELF = (CW + 1)'(X_POS);
   localparam logic [CW:0] Y_SELF = (CW + 1)'(Y_POS);

   logic signed [CW:0] x_diff;
   logic signed [CW:0] y_diff;

   // destination minus current
   assign x_diff = $signed({1'b0, q.head.dest_x}) - $signed(X_SELF);
   assign y_diff = $signed({1'b0, q.head.dest_y}) - $signed(Y_SELF);

   // dimension order
   // x first, then y, then local
   // y grows towards the south
   always_comb begin
      q.req = '0;
      if (q.valid) begin
         if (x_diff > 0) begin
            q.req[noc_pkg::PORT_E] = 1'b1;
         end else if (x_diff < 0) begin
            q.req[noc_pkg::PORT_W] = 1'b1;
         end else if (y_diff > 0) begin
            q.req[noc_pkg::PORT_S] = 1'b1;
         end else if (y_diff < 0) begin
            q.req[noc_pkg::PORT_N] = 1'b1;
         end else begin
            // arrived
            q.req[noc_pkg::PORT_L] = 1'b1;
         end
      end
   end

endmodule

/* logic/switch_allocator.sv */
`timescale 1ns/100ps

module switch_allocator (
   input  logic                                    clk,
   input  logic                                    rst_n,
   // one queue head per input
   head_if.alloc                                   q [noc_pkg::NUM_PORTS],
   // wishbone master side of the outputs
   input  logic           [noc_pkg::NUM_PORTS-1:0] out_ack,
   output logic           [noc_pkg::NUM_PORTS-1:0] out_cyc,
   output logic           [noc_pkg::NUM_PORTS-1:0] out_stb,
   // crossbar control
   output noc_pkg::port_e [noc_pkg::NUM_PORTS-1:0] sel,
   output logic           [noc_pkg::NUM_PORTS-1:0] load
);

   localparam int N = noc_pkg::NUM_PORTS;

   logic [N-1:0]   in_valid;
   logic [N-1:0]   pop;
   // req_m[input][output]
   logic [N-1:0]   req_m [N];
   logic [N-1:0]   busy;
   logic [N-1:0]   out_free;
   noc_pkg::port_e rr_ptr  [N];
   noc_pkg::port_e nxt_ptr [N];

   //////////////////////////////
   // flatten the head bundles
   //////////////////////////////

   for (genvar i = 0; i < N; i++) begin : g_in
      assign in_valid[i] = q[i].valid;
      assign req_m[i]    = q[i].req;
      assign q[i].pop    = pop[i];
   end

   // free when idle or finishing this cycle
   assign out_free = ~busy | out_ack;

   //////////////////////////////
   // round-robin per output
   //////////////////////////////

   always_comb begin
      int   idx;
      logic found;

      pop  = '0;
      load = '0;
      idx  = 0;
      for (int o = 0; o < N; o++) begin
         sel[o]     = noc_pkg::PORT_L;
         nxt_ptr[o] = rr_ptr[o];
         found      = 1'b0;
         if (out_free[o]) begin
            // first requester at or after the pointer
            for (int k = 0; k < N; k++) begin
               idx = (int'(rr_ptr[o]) + k) % N;
               if (!found && in_valid[idx] && req_m[idx][o]) begin
                  found      = 1'b1;
                  load[o]    = 1'b1;
                  sel[o]     = noc_pkg::port_e'(idx);
                  // req is one-hot, so an input wins at most one output
                  pop[idx]   = 1'b1;
                  // winner goes to the back of the line
                  nxt_ptr[o] = noc_pkg::port_e'((idx + 1) % N);
               end
            end
         end
      end
   end

   //////////////////////////////
   // output state
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= '0;
         for (int o = 0; o < N; o++) begin
            rr_ptr[o] <= noc_pkg::PORT_L;
         end
      end else begin
         for (int o = 0; o < N; o++) begin
            rr_ptr[o] <= nxt_ptr[o];
            // a new grant keeps the output busy through an ack
            if (load[o]) begin
               busy[o] <= 1'b1;
            end else if (out_ack[o]) begin
               busy[o] <= 1'b0;
            end
         end
      end
   end

   // cyc and stb move together, one flit per cycle
   assign out_cyc = busy;
   assign out_stb = busy;

endmodule

/* logic/crossbar.sv */
`timescale 1ns/100ps

module crossbar (
   input  logic                                     clk,
   // current queue heads, one per input
   input  flit_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] heads,
   // granted input per output
   input  noc_pkg::port_e  [noc_pkg::NUM_PORTS-1:0] sel,
   input  logic            [noc_pkg::NUM_PORTS-1:0] load,
   // output holding registers
   output flit_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] out_dat
);

   localparam int N = noc_pkg::NUM_PORTS;

   flit_pkg::flit_t [N-1:0] picked;

   // one mux per output
   for (genvar o = 0; o < N; o++) begin : g_mux
      assign picked[o] = heads[sel[o]];
   end

   // holding registers
   // only written on a grant, so data stays put while ack is withheld
   always_ff @(posedge clk) begin
      for (int o = 0; o < N; o++) begin
         if (load[o]) begin
            out_dat[o] <= picked[o];
         end
      end
   end

endmodule

/* logic/mesh_router.sv */
`timescale 1ns/100ps

module mesh_router #(
   parameter int X_POS      = 1,
   parameter int Y_POS      = 1,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                     clk,
   input  logic                                     rst_n,
   // input links, wishbone slaves
   input  logic            [noc_pkg::NUM_PORTS-1:0] in_cyc,
   input  logic            [noc_pkg::NUM_PORTS-1:0] in_stb,
   output logic            [noc_pkg::NUM_PORTS-1:0] in_ack,
   input  flit_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] in_dat,
   // output links, wishbone masters
   output logic            [noc_pkg::NUM_PORTS-1:0] out_cyc,
   output logic            [noc_pkg::NUM_PORTS-1:0] out_stb,
   input  logic            [noc_pkg::NUM_PORTS-1:0] out_ack,
   output flit_pkg::flit_t [noc_pkg::NUM_PORTS-1:0] out_dat
);

   localparam int N = noc_pkg::NUM_PORTS;

   // allocator to crossbar
   noc_pkg::port_e  [N-1:0] sel;
   logic            [N-1:0] load;
   // queue heads for the crossbar
   flit_pkg::flit_t [N-1:0] heads;

   // one head bundle per input
   head_if hif [N] ();

   //////////////////////////////
   // input side
   //////////////////////////////

   for (genvar i = 0; i < N; i++) begin : g_port
      // buffer and wishbone slave
      flit_fifo #(
         .FIFO_DEPTH (FIFO_DEPTH)
      ) u_flit_fifo (
         .clk   (clk),
         .rst_n (rst_n),
         .cyc   (in_cyc[i]),
         .stb   (in_stb[i]),
         .dat   (in_dat[i]),
         .ack   (in_ack[i]),
         .q     (hif[i])
      );

      // xy decision on the head
      route_compute #(
         .X_POS (X_POS),
         .Y_POS (Y_POS)
      ) u_route_compute (
         .q (hif[i])
      );

      assign heads[i] = hif[i].head;
   end

   //////////////////////////////
   // switch
   //////////////////////////////

   switch_allocator u_switch_allocator (
      .clk     (clk),
      .rst_n   (rst_n),
      .q       (hif),
      .out_ack (out_ack),
      .out_cyc (out_cyc),
      .out_stb (out_stb),
      .sel     (sel),
      .load    (load)
   );

   crossbar u_crossbar (
      .clk     (clk),
      .heads   (heads),
      .sel     (sel),
      .load    (load),
      .out_dat (out_dat)
   );

endmodule

/* sim/router_assertions.sv */
`timescale 1ns/100ps

module router_assertions (
   input logic                                    clk,
   input logic                                    rst_n,
   input logic           [noc_pkg::NUM_PORTS-1:0] in_valid,
   input logic           [noc_pkg::NUM_PORTS-1:0] pop,
   input logic           [noc_pkg::NUM_PORTS-1:0] load,
   input noc_pkg::port_e [noc_pkg::NUM_PORTS-1:0] sel,
   input logic           [noc_pkg::NUM_PORTS-1:0] out_stb,
   input logic           [noc_pkg::NUM_PORTS-1:0] out_ack
);

   localparam int N = noc_pkg::NUM_PORTS;

   // grant_of[input][output]
   logic [N-1:0] grant_of [N];

   always_comb begin
      for (int i = 0; i < N; i++) begin
         for (int o = 0; o < N; o++) begin
            grant_of[i][o] = load[o] && (int'(sel[o]) == i);
         end
      end
   end

   // index doubles as input and output, both have N ports
   for (genvar i = 0; i < N; i++) begin : g_chk
      // one output per input at most
      a_single_grant: assert property (@(posedge clk) disable iff (!rst_n)
         $onehot0(grant_of[i]))
         else $error("input %0d granted to more than one output", i);

      // no pop from an empty queue
      a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
         pop[i] |-> in_valid[i])
         else $error("pop on input %0d without a valid head", i);

      // waiting output keeps stb up
      a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
         (out_stb[i] && !out_ack[i]) |=> out_stb[i])
         else $error("out_stb %0d fell before out_ack", i);

      // no reload while waiting, so the holding register keeps its data
      a_dat_hold: assert property (@(posedge clk) disable iff (!rst_n)
         (out_stb[i] && !out_ack[i]) |-> !load[i])
         else $error("output %0d reloaded while waiting for out_ack", i);
   end

endmodule

// attached to every allocator
bind switch_allocator router_assertions u_router_assertions (
   .clk      (clk),
   .rst_n    (rst_n),
   .in_valid (in_valid),
   .pop      (pop),
   .load     (load),
   .sel      (sel),
   .out_stb  (out_stb),
   .out_ack  (out_ack)
);

/* sim/tb_mesh_router.sv */
`timescale 1ns/100ps

module tb_mesh_router;

   localparam int N          = noc_pkg::NUM_PORTS;
   localparam int X_POS      = 1;
   localparam int Y_POS      = 1;
   localparam int FIFO_DEPTH = 4;
   localparam int CLK_PERIOD = 100;

   // flits per test
   localparam int ROUTE_FLITS   = noc_pkg::X_NODES * noc_pkg::Y_NODES;
   localparam int RANDOM_FLITS  = 300;
   localparam int STALL_FLITS   = 200;
   localparam int FULL_FLITS    = FIFO_DEPTH + 3;
   localparam int CONTEND_FLITS = 32;
   localparam int TOTAL_FLITS   = ROUTE_FLITS + RANDOM_FLITS + STALL_FLITS + FULL_FLITS
                                  + CONTEND_FLITS;

   logic                    clk;
   logic                    rst_n   = 1'b0;
   logic            [N-1:0] in_cyc  = '0;
   logic            [N-1:0] in_stb  = '0;
   logic            [N-1:0] in_ack;
   flit_pkg::flit_t [N-1:0] in_dat  = '0;
   logic            [N-1:0] out_cyc;
   logic            [N-1:0] out_stb;
   logic            [N-1:0] out_ack = '0;
   flit_pkg::flit_t [N-1:0] out_dat;

   // flits still to send per input
   flit_pkg::flit_t sendq [N][$];
   // expected flits per input-output pair in order
   flit_pkg::flit_t expq [N][N][$];
   // ack seen in the cycle that just ended
   logic [N-1:0]    ack_seen    = '0;
   // outputs held without ack and the data they showed
   logic [N-1:0]    waiting     = '0;
   flit_pkg::flit_t held [N];
   int              accepted [N];
   int              seq [N];
   int              turns [N];
   logic [N-1:0]    stall_mask  = '0;
   logic            rand_stall  = 1'b0;
   logic            count_turns = 1'b0;
   logic [31:0]     rng         = 32'd76;
   string           test_name   = "reset";
   int              checks      = 0;
   int              errors      = 0;

   mesh_router #(
      .X_POS      (X_POS),
      .Y_POS      (Y_POS),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_mesh_router (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_cyc  (in_cyc),
      .in_stb  (in_stb),
      .in_ack  (in_ack),
      .in_dat  (in_dat),
      .out_cyc (out_cyc),
      .out_stb (out_stb),
      .out_ack (out_ack),
      .out_dat (out_dat)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // xy rule with x first and y growing to the south
   function automatic int xy_port(input flit_pkg::flit_t f);
      if (int'(f.dest_x) > X_POS) return int'(noc_pkg::PORT_E);
      if (int'(f.dest_x) < X_POS) return int'(noc_pkg::PORT_W);
      if (int'(f.dest_y) > Y_POS) return int'(noc_pkg::PORT_S);
      if (int'(f.dest_y) < Y_POS) return int'(noc_pkg::PORT_N);
      return int'(noc_pkg::PORT_L);
   endfunction

   function automatic logic all_idle();
      for (int i = 0; i < N; i++) begin
         if (sendq[i].size() != 0 || in_stb[i]) return 1'b0;
         for (int o = 0; o < N; o++) begin
            if (expq[i][o].size() != 0) return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   task automatic queue_flit(input int i, input int x, input int y);
      flit_pkg::flit_t f;
      f.dest_x  = 2'(x);
      f.dest_y  = 2'(y);
      // tag mod 5 names the input
      f.payload = 4'(i + N * (seq[i] % 3));
      seq[i]++;
      sendq[i].push_back(f);
   endtask

   task automatic wait_idle();
      while (!all_idle()) @(posedge clk);
   endtask

   task automatic random_traffic(input int n);
      for (int k = 0; k < n; k++) begin
         rng = xorshift(rng);
         queue_flit(int'(rng[10:8]) % N, int'(rng[1:0]), int'(rng[3:2]));
      end
      wait_idle();
   endtask

   //////////////////////////////
   // link agents
   //////////////////////////////

   always @(posedge clk) begin : step
      int              p;
      int              src;
      flit_pkg::flit_t exp_f;
      logic            stall;
      logic            active;

      active = rst_n;
      #10;
      if (active) begin
         // wishbone masters on the inputs
         for (int i = 0; i < N; i++) begin
            if (in_stb[i] && ack_seen[i]) begin
               // write completed on the last edge
               p = xy_port(in_dat[i]);
               expq[i][p].push_back(in_dat[i]);
               accepted[i]++;
               void'(sendq[i].pop_front());
               in_cyc[i] = 1'b0;
               in_stb[i] = 1'b0;
            end
            ack_seen[i] = in_ack[i];
            if (!in_stb[i] && sendq[i].size() != 0) begin
               in_cyc[i] = 1'b1;
               in_stb[i] = 1'b1;
               in_dat[i] = sendq[i][0];
            end
         end
         // stalling slaves on the outputs
         for (int o = 0; o < N; o++) begin
            checks++;
            assert (out_cyc[o] == out_stb[o]) else begin
               errors++;
               $display("Output %0d out_cyc does not follow out_stb in %s", o, test_name);
            end
            if (out_stb[o]) begin
               if (waiting[o]) begin
                  checks++;
                  assert (out_dat[o] == held[o]) else begin
                     errors++;
                     $display("Error: %s out_dat %0d held, expected %h actual %h",
                              test_name, o, held[o], out_dat[o]);
                  end
               end
               rng        = xorshift(rng);
               stall      = stall_mask[o] || (rand_stall && (rng % 5) < 2);
               out_ack[o] = !stall;
               waiting[o] = stall;
               held[o]    = out_dat[o];
               if (!stall) begin
                  src = int'(out_dat[o].payload) % N;
                  checks++;
                  assert (expq[src][o].size() != 0) else begin
                     errors++;
                     $display("Flit %h on output %0d was never sent there (%s)",
                              out_dat[o], o, test_name);
                  end
                  if (expq[src][o].size() != 0) begin
                     exp_f = expq[src][o].pop_front();
                     checks++;
                     assert (out_dat[o] == exp_f) else begin
                        errors++;
                        $display("Error: %s output %0d expected %h actual %h",
                                 test_name, o, exp_f, out_dat[o]);
                     end
                     // round-robin on the local output
                     if (count_turns && o == int'(noc_pkg::PORT_L)) begin
                        turns[src]++;
                        for (int j = 1; j < N; j++) begin
                           checks++;
                           assert (turns[src] < 3 || turns[j] > 0) else begin
                              errors++;
                              $display("Input %0d got a third turn before input %0d",
                                       src, j);
                           end
                        end
                     end
                  end
               end
            end else begin
               checks++;
               assert (!waiting[o]) else begin
                  errors++;
                  $display("Output %0d dropped out_stb before out_ack in %s", o, test_name);
               end
               out_ack[o] = 1'b0;
               waiting[o] = 1'b0;
            end
         end
      end
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin
      int base;

      repeat (4) @(posedge clk);
      #10;
      rst_n = 1'b1;
      checks++;
      assert (in_ack == '0 && out_cyc == '0 && out_stb == '0) else begin
         errors++;
         $display("Handshake outputs are not low after reset");
      end
      @(posedge clk);

      // every destination from the local input
      test_name = "routing";
      for (int y = 0; y < noc_pkg::Y_NODES; y++) begin
         for (int x = 0; x < noc_pkg::X_NODES; x++) begin
            queue_flit(int'(noc_pkg::PORT_L), x, y);
            wait_idle();
         end
      end

      test_name = "random";
      random_traffic(RANDOM_FLITS);

      test_name  = "backpressure";
      rand_stall = 1'b1;
      random_traffic(STALL_FLITS);
      rand_stall = 1'b0;

      // local input fills up while east is blocked
      test_name = "full_buffer";
      stall_mask[noc_pkg::PORT_E] = 1'b1;
      base = accepted[0];
      for (int k = 0; k < FULL_FLITS; k++) begin
         queue_flit(int'(noc_pkg::PORT_L), X_POS + 1 + k % 2, k % noc_pkg::Y_NODES);
      end
      repeat (40) @(posedge clk);
      checks++;
      assert (accepted[0] - base == FIFO_DEPTH + 1) else begin
         errors++;
         $display("Error: %s accepted flits expected %0d actual %0d",
                  test_name, FIFO_DEPTH + 1, accepted[0] - base);
      end
      stall_mask = '0;
      wait_idle();

      // four inputs to local at once
      test_name   = "contention";
      count_turns = 1'b1;
      for (int k = 0; k < CONTEND_FLITS / 4; k++) begin
         for (int i = 1; i < N; i++) begin
            queue_flit(i, X_POS, Y_POS);
         end
      end
      wait_idle();
      count_turns = 1'b0;

      // duplicates would show up here
      repeat (5) @(posedge clk);
      checks++;
      assert (out_stb == '0) else begin
         errors++;
         $display("Outputs still strobe after all flits were delivered");
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog allows 20 cycles per flit
   initial begin
      #(TOTAL_FLITS * 20 * CLK_PERIOD);
      $display("Timeout: traffic did not drain in %0d cycles", TOTAL_FLITS * 20);
      $display("Test failed");
      $finish;
   end

endmodule

/* flist.f */
logic/noc_pkg.sv
logic/flit_pkg.sv
logic/head_if.sv
logic/flit_fifo.sv
logic/route_compute.sv
logic/switch_allocator.sv
logic/crossbar.sv
logic/mesh_router.sv
sim/router_assertions.sv
sim/tb_mesh_router.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the router testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mesh_router \
   -f flist.f -o vtb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/vtb > "$LOG" 2>&1
cat "$LOG"

# fail message or a missing pass message means failure
grep -q "Test failed" "$LOG" && exit 1
grep -q "Test passed" "$LOG" || exit 1
exit 0
